//--- logic/hazardDetect.sv
`timescale 1ns/100ps

module hazardDetect import pipePkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  opcode_t     fetchOpcode,
    input  stageRec_t   ifId,
    input  stageRec_t   idEx,
    input  stageRec_t   exMem,
    input  stageRec_t   memWb,
    output logic        pcWriteDisable,
    output logic        ifIdWriteDisable,
    output logic        exNop,
    output logic        fetchNop,
    output forwardSel_t forward
);

    logic idExValid;
    logic exMemValid;
    logic memWbValid;
    logic rawIdExReg1;
    logic rawIdExReg2;
    logic rawIdEx;
    logic ifIdIsStore;
    logic fwdCovers;
    logic dataHazard;
    logic controlHazard;
    logic fetchNopNext;

    // Jumps and branches both redirect the PC late in the pipe
    function automatic logic isControl(input opcode_t op);
        return (op[4:2] == JUMP_CLASS) | (op[4:2] == BRANCH_CLASS);
    endfunction

    // A stage with PC zero holds a bubble
    assign idExValid = |idEx.pc;
    assign exMemValid = |exMem.pc;
    assign memWbValid = |memWb.pc;

    // EX to EX forwarding, impossible when the producer is a load still in MEM
    assign forward.exExReg1 = idExValid & exMemValid & ~idEx.ignoreReg1 & ~exMem.memRead &
                              (idEx.readReg1 == exMem.writeReg);
    assign forward.exExReg2 = idExValid & exMemValid & ~idEx.ignoreReg2 & ~exMem.memRead &
                              (idEx.readReg2 == exMem.writeReg);

    // MEM/WB result into an EX operand
    assign forward.memExReg1 = idExValid & memWbValid & ~idEx.ignoreReg1 &
                               (idEx.readReg1 == memWb.writeReg);
    assign forward.memExReg2 = idExValid & memWbValid & ~idEx.ignoreReg2 &
                               (idEx.readReg2 == memWb.writeReg);

    // Load result straight into the data of a following store, e.g. LD R1 then ST R1
    assign forward.memMem = exMemValid & memWbValid & ~exMem.ignoreReg2 &
                            (exMem.readReg2 == memWb.writeReg);

    // Instruction in decode reads what the instruction in execute will write
    assign rawIdExReg1 = ~ifId.ignoreReg1 & (ifId.readReg1 == idEx.writeReg);
    assign rawIdExReg2 = ~ifId.ignoreReg2 & (ifId.readReg2 == idEx.writeReg);
    assign rawIdEx = idExValid & (rawIdExReg1 | rawIdExReg2);

    assign ifIdIsStore = (ifId.opcode == OP_ST) | (ifId.opcode == OP_STU);

    // A RAW on EX/MEM is always served by MEM to EX forwarding one cycle later
    // A RAW on ID/EX is served by EX to EX forwarding unless the producer is a load
    // Store data behind a load is still fine, MEM to MEM forwarding picks it up
    assign fwdCovers = ~idEx.memRead | (ifIdIsStore & ~rawIdExReg1);

    // So only a load-use pair stalls, and for exactly one cycle
    assign dataHazard = ~reset & rawIdEx & ~fwdCovers;

    assign controlHazard = isControl(fetchOpcode) | isControl(ifId.opcode) |
                           isControl(idEx.opcode) | isControl(exMem.opcode);

    // HALT freezes the PC so nothing past the program end gets fetched
    assign pcWriteDisable = dataHazard | controlHazard | (fetchOpcode == OP_HALT);

    // Stalled decode instruction waits in IF/ID while a bubble goes to execute
    assign ifIdWriteDisable = dataHazard;
    assign exNop = dataHazard;

    // Fetch turns into a NOP while a jump or branch is in flight
    // During a stall this only happens once fetch already holds a NOP
    assign fetchNopNext = (controlHazard & ~dataHazard) |
                          (controlHazard & dataHazard & (fetchOpcode == OP_NOP));

    // The request acts on the next fetch, hence the register
    always_ff @(posedge clk) begin
        if (reset) begin
            fetchNop <= 1'b0;
        end else begin
            fetchNop <= fetchNopNext;
        end
    end

endmodule

//--- logic/instrDecode.sv
`timescale 1ns/100ps

module instrDecode import pipePkg::*; (
    input  instr_t    instr,
    input  pc_t       pc,
    output stageRec_t rec
);

    opcode_t opcode;
    logic    isImm;
    logic    isJump;
    logic    isBranch;
    logic    isRType;
    logic    isLoad;
    logic    isLbi;
    logic    isSlbi;
    logic    isNop;
    logic    isHalt;

    assign opcode = instr[15:11];

    // Immediate forms carry their destination in bits 7..5
    // Loads are immediate-offset too, so they fall into this group
    assign isImm = (opcode[4:2] == 3'b010) | (opcode[4:2] == 3'b101) | (opcode == OP_LD);

    assign isJump = opcode[4:2] == JUMP_CLASS;
    assign isBranch = opcode[4:2] == BRANCH_CLASS;

    // The two register-register opcodes 11010 and 11011
    assign isRType = opcode[4:1] == 4'b1101;

    assign isLoad = opcode == OP_LD;
    assign isLbi = opcode == OP_LBI;
    assign isSlbi = opcode == OP_SLBI;
    assign isNop = opcode == OP_NOP;
    assign isHalt = opcode == OP_HALT;

    always_comb begin
        rec = '0;
        rec.opcode = opcode;
        rec.pc = pc;
        // Source fields are always extracted, the ignore flags say if they are real
        rec.readReg1 = {1'b0, instr[10:8]};
        rec.readReg2 = {1'b0, instr[7:5]};
        rec.memRead = isLoad;

        // Destination field depends on the instruction class
        if (isRType) begin
            rec.writeReg = {1'b0, instr[4:2]};
        end else if (isImm) begin
            rec.writeReg = {1'b0, instr[7:5]};
        end else if (isLbi | isSlbi) begin
            rec.writeReg = {1'b0, instr[10:8]};
        end else if (opcode == OP_JAL) begin
            // JAL links into R7
            rec.writeReg = 4'd7;
        end else begin
            rec.writeReg = NO_REG;
        end

        // Bits 10..8 are no register for JMP, JAL, LBI, NOP and HALT
        rec.ignoreReg1 = (opcode == OP_JMP) | (opcode == OP_JAL) | isLbi | isNop | isHalt;

        // Bits 7..5 hold immediate bits for jumps, branches and immediate forms
        // BTR and the byte loads have only one source as well
        rec.ignoreReg2 = isJump | isBranch | isLbi | isSlbi | (opcode == OP_BTR) | isNop |
                         isHalt | isImm;
    end

endmodule

//--- logic/pipePkg.sv
package pipePkg;

    // Register number, one bit wider than the 3-bit instruction fields
    // The extra bit lets NO_REG name a register that no instruction can read
    typedef logic [3:0] regId_t;
    typedef logic [4:0] opcode_t;
    typedef logic [15:0] pc_t;
    typedef logic [15:0] instr_t;

    // Opcodes that the decoder and the hazard unit single out
    localparam opcode_t OP_HALT = 5'b00000;
    localparam opcode_t OP_NOP = 5'b00001;
    localparam opcode_t OP_JMP = 5'b00100;
    localparam opcode_t OP_JAL = 5'b00110;
    localparam opcode_t OP_ST = 5'b10000;
    localparam opcode_t OP_LD = 5'b10001;
    localparam opcode_t OP_SLBI = 5'b10010;
    localparam opcode_t OP_STU = 5'b10011;
    localparam opcode_t OP_LBI = 5'b11000;
    localparam opcode_t OP_BTR = 5'b11001;

    // Class prefixes, compared against opcode bits 4..2
    localparam logic [2:0] JUMP_CLASS = 3'b001;
    localparam logic [2:0] BRANCH_CLASS = 3'b011;

    // Destination of an instruction that writes no register
    localparam regId_t NO_REG = 4'h8;

    // Metadata of one instruction as it moves down the pipeline
    // The all-zero record is a bubble and is recognized by its zero PC
    typedef struct packed {
        opcode_t opcode;
        pc_t     pc;
        regId_t  readReg1;
        regId_t  readReg2;
        regId_t  writeReg;
        logic    ignoreReg1;
        logic    ignoreReg2;
        logic    memRead;
    } stageRec_t;

    // Forwarding selects for the two EX operands and the store data at MEM
    typedef struct packed {
        logic exExReg1;
        logic exExReg2;
        logic memExReg1;
        logic memExReg2;
        logic memMem;
    } forwardSel_t;

endpackage

//--- logic/pipelineControl.sv
`timescale 1ns/100ps

module pipelineControl import pipePkg::*; #(
    parameter pc_t RESET_PC = 16'h0002
) (
    input  logic        clk,
    input  logic        reset,
    input  instr_t      fetchInstr,
    input  pc_t         fetchPc,
    output logic        pcWriteDisable,
    output forwardSel_t forward
);

    // Record of the word currently on the fetch bus
    stageRec_t fetchRec;

    // Latch contents as the datapath would hold them
    stageRec_t ifId;
    stageRec_t idEx;
    stageRec_t exMem;
    stageRec_t memWb;

    // Fetch opcode after NOP insertion
    opcode_t fetchOpcode;

    // Feedback from the hazard unit into the latches
    logic ifIdWriteDisable;
    logic exNop;
    logic fetchNop;

    instrDecode instrDecode_i (
        .instr (fetchInstr),
        .pc    (fetchPc),
        .rec   (fetchRec)
    );

    stageTrack #(
        .RESET_PC (RESET_PC)
    ) stageTrack_i (
        .clk              (clk),
        .reset            (reset),
        .fetchRec         (fetchRec),
        .ifIdWriteDisable (ifIdWriteDisable),
        .exNop            (exNop),
        .fetchNop         (fetchNop),
        .fetchOpcode      (fetchOpcode),
        .ifId             (ifId),
        .idEx             (idEx),
        .exMem            (exMem),
        .memWb            (memWb)
    );

    // Stall, bubble and fetch-NOP outputs feed back into the tracker
    hazardDetect hazardDetect_i (
        .clk              (clk),
        .reset            (reset),
        .fetchOpcode      (fetchOpcode),
        .ifId             (ifId),
        .idEx             (idEx),
        .exMem            (exMem),
        .memWb            (memWb),
        .pcWriteDisable   (pcWriteDisable),
        .ifIdWriteDisable (ifIdWriteDisable),
        .exNop            (exNop),
        .fetchNop         (fetchNop),
        .forward          (forward)
    );

endmodule

//--- logic/stageTrack.sv
`timescale 1ns/100ps

module stageTrack import pipePkg::*; #(
    parameter pc_t RESET_PC = 16'h0002
) (
    input  logic      clk,
    input  logic      reset,
    input  stageRec_t fetchRec,
    input  logic      ifIdWriteDisable,
    input  logic      exNop,
    input  logic      fetchNop,
    output opcode_t   fetchOpcode,
    output stageRec_t ifId,
    output stageRec_t idEx,
    output stageRec_t exMem,
    output stageRec_t memWb
);

    // Builds the record of a NOP that the fetch stage inserts
    // It reads nothing and writes nothing, but keeps a real PC
    function automatic stageRec_t nopRec(input pc_t pc);
        stageRec_t rec;
        rec = '0;
        rec.opcode = OP_NOP;
        rec.pc = pc;
        rec.writeReg = NO_REG;
        rec.ignoreReg1 = 1'b1;
        rec.ignoreReg2 = 1'b1;
        return rec;
    endfunction

    // While fetchNop is high the fetch stage really holds a NOP
    // The hazard unit must see that opcode, not the word on the bus
    assign fetchOpcode = fetchNop ? OP_NOP : fetchRec.opcode;

    always_ff @(posedge clk) begin
        if (reset) begin
            // IF/ID starts with a NOP at the reset PC
            ifId <= nopRec(RESET_PC);
            idEx <= '0;
            exMem <= '0;
            memWb <= '0;
        end else begin
            // A stalled IF/ID keeps its instruction for the next try
            if (!ifIdWriteDisable) begin
                if (fetchNop) begin
                    ifId <= nopRec(fetchRec.pc);
                end else begin
                    ifId <= fetchRec;
                end
            end

            // A bubble enters execute in place of the stalled instruction
            if (exNop) begin
                idEx <= '0;
            end else begin
                idEx <= ifId;
            end

            // The older stages never stall
            exMem <= idEx;
            memWb <= exMem;
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# Builds the pipelineControl testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module pipelineControlTb \
    -o pipelineControlSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/pipelineControlSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF '** FAIL **' "$LOG"; then
    exit 1
fi
exit 0

//--- sim/pipelineControlChk.sv
`timescale 1ns/100ps

module pipelineControl_chk import pipePkg::*; (
    input logic        clk,
    input logic        reset,
    input opcode_t     fetchOpcode,
    input logic        pcWriteDisable,
    input logic        ifIdWriteDisable,
    input logic        exNop,
    input forwardSel_t forward
);

    // The bubble behind a load-use stall takes the producer out of ID/EX
    // So a stall can never repeat in the following cycle
    stallLastsOneCycle: assert property (@(posedge clk) ifIdWriteDisable |=> !ifIdWriteDisable)
        else $error("ifIdWriteDisable high in two cycles in a row");

    // A bubble sent into execute never takes a forwarded operand
    bubbleTakesNoForward: assert property (@(posedge clk)
        exNop |=> !(forward.exExReg1 | forward.exExReg2 | forward.memExReg1 | forward.memExReg2))
        else $error("forwarding into the bubble behind a stall");

    // Reset leaves no jump or branch in the latches, so only fetch can freeze the PC
    resetFreezeFromFetchOnly: assert property (@(posedge clk)
        (reset && $past(reset) && fetchOpcode == OP_NOP) |-> !pcWriteDisable)
        else $error("pcWriteDisable high during reset with a NOP at fetch");

endmodule

bind hazardDetect pipelineControl_chk pipelineControl_chk_i (
    .clk              (clk),
    .reset            (reset),
    .fetchOpcode      (fetchOpcode),
    .pcWriteDisable   (pcWriteDisable),
    .ifIdWriteDisable (ifIdWriteDisable),
    .exNop            (exNop),
    .forward          (forward)
);

//--- sim/pipelineControlTb.sv
`timescale 1ns/100ps

module pipelineControlTb import pipePkg::*; ();

    localparam int CLK_PERIOD = 20;
    // Reset plus every fetch cycle of the tests and a margin for the watchdog
    localparam int TEST_CYCLES = 50;
    localparam int MARGIN_CYCLES = 50;

    localparam instr_t NOP_WORD = {OP_NOP, 11'd0};
    localparam instr_t HALT_WORD = {OP_HALT, 11'd0};
    // BEQZ R1 with a small offset
    localparam instr_t BRANCH_WORD = {5'b01100, 3'd1, 8'h04};

    // Order is exExReg1, exExReg2, memExReg1, memExReg2, memMem
    localparam forwardSel_t FWD_NONE = 5'b00000;
    localparam forwardSel_t FWD_EXEX1 = 5'b10000;
    localparam forwardSel_t FWD_MEMEX1 = 5'b00100;
    localparam forwardSel_t FWD_MEMEX2 = 5'b00010;
    localparam forwardSel_t FWD_MEMMEM = 5'b00001;

    logic        clk;
    logic        reset;
    instr_t      fetchInstr;
    pc_t         fetchPc;
    logic        pcWriteDisable;
    forwardSel_t forward;

    int  seed;
    int  passCount;
    int  failCount;
    int  testErrors;
    pc_t nextPc;

    pipelineControl #(
        .RESET_PC (16'h0004)
    ) pipelineControl_i (
        .clk            (clk),
        .reset          (reset),
        .fetchInstr     (fetchInstr),
        .fetchPc        (fetchPc),
        .pcWriteDisable (pcWriteDisable),
        .forward        (forward)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Register-register word with sources in 10..8 and 7..5 and the destination in 4..2
    function automatic instr_t rType(input logic [2:0] rs, input logic [2:0] rt,
                                     input logic [2:0] rd);
        return {5'b11011, rs, rt, rd, 2'b00};
    endfunction

    // Load and store words carry the base in 10..8 and the data register in 7..5
    function automatic instr_t memOp(input opcode_t op, input logic [2:0] rs,
                                     input logic [2:0] rt);
        return {op, rs, rt, 5'd0};
    endfunction

    // Filler reads R0 and writes one of R4..R7 that no test instruction touches
    function automatic instr_t filler();
        logic [31:0] r;
        r = $random(seed);
        return rType(3'd0, 3'd0, {1'b1, r[1:0]});
    endfunction

    task automatic compareForward(input forwardSel_t expected, input string what);
        if (forward !== expected) begin
            $display("ERROR at %0t ns: %s forward is %b, expected %b", $time, what, forward,
                     expected);
            testErrors++;
            failCount++;
        end else begin
            passCount++;
        end
    endtask

    task automatic compareLogic(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
            testErrors++;
            failCount++;
        end else begin
            passCount++;
        end
    endtask

    // One fetch cycle; a held word keeps its PC as a frozen PC would
    task automatic step(input instr_t word, input logic hold, input forwardSel_t expFwd,
                        input logic expStall, input string what);
        @(negedge clk);
        if (!hold) begin
            nextPc = nextPc + 16'd2;
        end
        fetchInstr = word;
        fetchPc = nextPc;
        // Outputs settle well before the next rising edge
        #1;
        compareForward(expFwd, what);
        compareLogic(pcWriteDisable, expStall, {what, " pcWriteDisable"});
    endtask

    task automatic pad(input int count);
        repeat (count) step(filler(), 1'b0, FWD_NONE, 1'b0, "filler");
    endtask

    task automatic reportTest(input string name);
        $display("Test %s: %s with %0d errors", name, (testErrors == 0) ? "ok" : "failed",
                 testErrors);
        testErrors = 0;
    endtask

    task automatic testReset();
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #1;
        compareForward(FWD_NONE, "out of reset");
        compareLogic(pcWriteDisable, 1'b0, "out of reset pcWriteDisable");
        step(NOP_WORD, 1'b0, FWD_NONE, 1'b0, "nop fetch");
        step(NOP_WORD, 1'b0, FWD_NONE, 1'b0, "nop fetch");
        step(filler(), 1'b0, FWD_NONE, 1'b0, "first filler");
        reportTest("reset");
    endtask

    // HALT ends the program and its word stays on the bus behind the frozen PC
    task automatic testHalt();
        step(HALT_WORD, 1'b0, FWD_NONE, 1'b1, "halt at fetch");
        step(HALT_WORD, 1'b1, FWD_NONE, 1'b1, "halt held at fetch");
        reportTest("halt");
    endtask

    // R3 is produced and then read one and two instructions later
    task automatic testAluForward();
        step(rType(3'd1, 3'd2, 3'd3), 1'b0, FWD_NONE, 1'b0, "alu producer");
        step(rType(3'd3, 3'd0, 3'd1), 1'b0, FWD_NONE, 1'b0, "exex reader");
        step(rType(3'd0, 3'd3, 3'd2), 1'b0, FWD_NONE, 1'b0, "memex reader");
        step(filler(), 1'b0, FWD_EXEX1, 1'b0, "exex reader in ID/EX");
        step(filler(), 1'b0, FWD_MEMEX2, 1'b0, "memex reader in ID/EX");
        step(filler(), 1'b0, FWD_NONE, 1'b0, "alu tail");
        reportTest("alu forward");
    endtask

    // LD R1 then a reader of R1 costs one stall and then takes MEM to EX
    task automatic testLoadUse();
        instr_t heldWord;
        heldWord = filler();
        step(memOp(OP_LD, 3'd2, 3'd1), 1'b0, FWD_NONE, 1'b0, "load");
        step(rType(3'd1, 3'd0, 3'd3), 1'b0, FWD_NONE, 1'b0, "load user");
        step(heldWord, 1'b0, FWD_NONE, 1'b1, "load-use stall");
        step(heldWord, 1'b1, FWD_NONE, 1'b0, "bubble in ID/EX");
        step(filler(), 1'b0, FWD_MEMEX1, 1'b0, "load user in ID/EX");
        step(filler(), 1'b0, FWD_NONE, 1'b0, "load tail");
        reportTest("load use");
    endtask

    // Store data R1 right behind LD R1 is served at MEM without a stall
    task automatic testStoreForward();
        step(memOp(OP_LD, 3'd2, 3'd1), 1'b0, FWD_NONE, 1'b0, "load");
        step(memOp(OP_ST, 3'd3, 3'd1), 1'b0, FWD_NONE, 1'b0, "store after load");
        step(filler(), 1'b0, FWD_NONE, 1'b0, "store in IF/ID");
        step(filler(), 1'b0, FWD_NONE, 1'b0, "store in ID/EX");
        step(filler(), 1'b0, FWD_MEMMEM, 1'b0, "store in EX/MEM");
        step(filler(), 1'b0, FWD_NONE, 1'b0, "store tail");
        reportTest("store forward");
    endtask

    // The branch word stays on the bus while the PC is frozen
    task automatic testBranch();
        step(BRANCH_WORD, 1'b0, FWD_NONE, 1'b1, "branch at fetch");
        step(BRANCH_WORD, 1'b1, FWD_NONE, 1'b1, "branch in IF/ID");
        step(BRANCH_WORD, 1'b1, FWD_NONE, 1'b1, "branch in ID/EX");
        step(BRANCH_WORD, 1'b1, FWD_NONE, 1'b1, "branch in EX/MEM");
        step(BRANCH_WORD, 1'b1, FWD_NONE, 1'b0, "branch in MEM/WB");
        step(filler(), 1'b0, FWD_NONE, 1'b0, "after branch");
        reportTest("branch");
    endtask

    initial begin
        seed = 32'h5df0eeab;
        passCount = 0;
        failCount = 0;
        testErrors = 0;
        nextPc = 16'h0010;
        reset = 1'b1;
        fetchInstr = NOP_WORD;
        fetchPc = nextPc;
        testReset();
        pad(2);
        testAluForward();
        pad(2);
        testLoadUse();
        pad(2);
        testStoreForward();
        pad(2);
        testBranch();
        testHalt();
        $display("Checks passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Watchdog timeout: the tests did not finish in time");
        $display("** FAIL **");
        $finish;
    end

endmodule

//--- verilog.f
logic/pipePkg.sv
logic/instrDecode.sv
logic/stageTrack.sv
logic/hazardDetect.sv
logic/pipelineControl.sv
sim/pipelineControlChk.sv
sim/pipelineControlTb.sv
